// ==== pu_pkg.sv ====
// Processing unit shared definitions
package pu_pkg;

	localparam int DATA_W = 32;
	localparam int ADDR_W = 30;
	localparam int SEL_W = 4;
	localparam int GPR_CNT = 16;
	localparam int OP_W = 8;
	localparam int ST_W = 3;

	// Operation codes on pi1.
	localparam logic [1:0] MEM_NOOP = 2'b00;
	localparam logic [1:0] MEM_WRITE = 2'b01;
	localparam logic [1:0] MEM_READ = 2'b10;

	localparam logic [OP_W-1:0] OP_ADD = 8'h01;
	localparam logic [OP_W-1:0] OP_SUB = 8'h02;
	localparam logic [OP_W-1:0] OP_AND = 8'h03;
	localparam logic [OP_W-1:0] OP_OR = 8'h04;
	localparam logic [OP_W-1:0] OP_XOR = 8'h05;
	localparam logic [OP_W-1:0] OP_SLL = 8'h06;
	localparam logic [OP_W-1:0] OP_SRL = 8'h07;
	localparam logic [OP_W-1:0] OP_ADDI = 8'h10;
	localparam logic [OP_W-1:0] OP_LI = 8'h11;
	localparam logic [OP_W-1:0] OP_LD = 8'h20;
	localparam logic [OP_W-1:0] OP_ST = 8'h21;
	localparam logic [OP_W-1:0] OP_STB = 8'h22;
	localparam logic [OP_W-1:0] OP_JZ = 8'h30;
	localparam logic [OP_W-1:0] OP_MUL = 8'h40;
	localparam logic [OP_W-1:0] OP_DIVU = 8'h41;
	localparam logic [OP_W-1:0] OP_REMU = 8'h42;
	localparam logic [OP_W-1:0] OP_GETSYS = 8'h50;
	localparam logic [OP_W-1:0] OP_EI = 8'h51;
	localparam logic [OP_W-1:0] OP_IRET = 8'h52;
	localparam logic [OP_W-1:0] OP_HALT = 8'h53;

	// System register selectors, given in the immediate field of OP_GETSYS.
	localparam logic [15:0] SYS_ID = 16'h0000;
	localparam logic [15:0] SYS_EPC = 16'h0001;

	localparam logic [DATA_W-1:0] INTR_VECTOR = 32'h0000_0800; // Byte address.

	// Sequencer states.
	localparam logic [ST_W-1:0] ST_FETCH = 3'd0;
	localparam logic [ST_W-1:0] ST_FWAIT = 3'd1;
	localparam logic [ST_W-1:0] ST_EXEC = 3'd2;
	localparam logic [ST_W-1:0] ST_MWAIT = 3'd3;
	localparam logic [ST_W-1:0] ST_MDWAIT = 3'd4;
	localparam logic [ST_W-1:0] ST_HALT = 3'd5;

	// One instruction word, seen in register or immediate format.
	typedef union packed {
		struct packed {
			logic [7:0] opcode;
			logic [3:0] rd;
			logic [3:0] ra;
			logic [3:0] rb;
			logic [11:0] unused;
		} r;
		struct packed {
			logic [7:0] opcode;
			logic [3:0] rd;
			logic [3:0] ra;
			logic [15:0] imm;
		} i;
	} pu_instr_u;

endpackage

// ==== pu_gpr.sv ====
// General-purpose register file
module pu_gpr import pu_pkg::*; (
	input logic clk_i,
	input logic [$clog2(GPR_CNT)-1:0] ra_idx_i,
	input logic [$clog2(GPR_CNT)-1:0] rb_idx_i,
	input logic [$clog2(GPR_CNT)-1:0] rd_idx_i,
	input logic we_i,
	input logic [DATA_W-1:0] wdata_i,
	output logic [DATA_W-1:0] ra_data_o,
	output logic [DATA_W-1:0] rb_data_o,
	output logic [DATA_W-1:0] rd_data_o
);

	logic [DATA_W-1:0] regs_q [GPR_CNT];

	// The destination index also addresses the write port.
	always_ff @(posedge clk_i) begin
		if (we_i) begin
			regs_q[rd_idx_i] <= wdata_i;
		end
	end

	assign ra_data_o = regs_q[ra_idx_i];
	assign rb_data_o = regs_q[rb_idx_i];
	assign rd_data_o = regs_q[rd_idx_i]; // Store data.

endmodule

// ==== pu_alu.sv ====
// Arithmetic and logic unit
module pu_alu import pu_pkg::*; (
	input logic [OP_W-1:0] op_i,
	input logic [DATA_W-1:0] a_i,
	input logic [DATA_W-1:0] b_i,
	output logic [DATA_W-1:0] result_o,
	output logic zero_o
);

	always_comb begin
		case (op_i)
			OP_ADD, OP_ADDI: begin
				result_o = a_i + b_i;
			end
			OP_SUB: begin
				result_o = a_i - b_i;
			end
			OP_AND: begin
				result_o = a_i & b_i;
			end
			OP_OR: begin
				result_o = a_i | b_i;
			end
			OP_XOR: begin
				result_o = a_i ^ b_i;
			end
			OP_SLL: begin
				result_o = a_i << b_i[4:0];
			end
			OP_SRL: begin
				result_o = a_i >> b_i[4:0];
			end
			OP_LI: begin
				result_o = b_i; // The immediate arrives already extended.
			end
			default: begin
				result_o = '0;
			end
		endcase
	end

	// Branch condition for OP_JZ.
	assign zero_o = (a_i == '0);

endmodule

// ==== pu_muldiv.sv ====
// Iterative multiply and divide unit
module pu_muldiv import pu_pkg::*; (
	input logic clk_i,
	input logic reset_i,
	input logic start_i,
	input logic [OP_W-1:0] op_i,
	input logic [DATA_W-1:0] a_i,
	input logic [DATA_W-1:0] b_i,
	output logic done_o,
	output logic [DATA_W-1:0] result_o
);

	logic busy_q;
	logic [4:0] step_q;
	logic [OP_W-1:0] op_q;
	logic [DATA_W-1:0] hi_q;
	logic [DATA_W-1:0] lo_q;
	logic [DATA_W-1:0] b_q;
	logic [DATA_W:0] rem_sh;
	logic [DATA_W:0] rem_diff;
	logic rem_ge;

	// One restoring division step on the partial remainder.
	assign rem_sh = {hi_q, lo_q[DATA_W-1]};
	assign rem_diff = rem_sh - {1'b0, b_q};
	assign rem_ge = (rem_sh >= {1'b0, b_q});

	always_ff @(posedge clk_i) begin
		done_o <= 1'b0;
		if (reset_i) begin
			busy_q <= 1'b0;
			step_q <= '0;
		end else if (start_i) begin
			busy_q <= 1'b1;
			step_q <= '0;
		end else if (busy_q) begin
			step_q <= step_q + 1'b1;
			if (&step_q) begin
				busy_q <= 1'b0;
				done_o <= 1'b1; // Lands 33 cycles after the start pulse.
			end
		end
	end

	// For a multiply hi_q accumulates, lo_q is the multiplier and b_q the shifted multiplicand.
	// For a divide hi_q is the remainder, lo_q turns from dividend into quotient.
	always_ff @(posedge clk_i) begin
		if (start_i) begin
			op_q <= op_i;
			hi_q <= '0;
			lo_q <= (op_i == OP_MUL) ? b_i : a_i;
			b_q <= (op_i == OP_MUL) ? a_i : b_i;
		end else if (busy_q) begin
			if (op_q == OP_MUL) begin
				if (lo_q[0]) begin
					hi_q <= hi_q + b_q;
				end
				lo_q <= lo_q >> 1;
				b_q <= b_q << 1;
			end else begin
				hi_q <= rem_ge ? rem_diff[DATA_W-1:0] : rem_sh[DATA_W-1:0];
				lo_q <= {lo_q[DATA_W-2:0], rem_ge};
			end
		end
	end

	assign result_o = (op_q == OP_DIVU) ? lo_q : hi_q;

endmodule

// ==== pu_memctrl.sv ====
// Memory controller for the pi1 port
module pu_memctrl import pu_pkg::*; (
	input logic clk_i,
	input logic reset_i,
	input logic req_i,
	input logic we_i,
	input logic [ADDR_W-1:0] addr_i,
	input logic [DATA_W-1:0] wdata_i,
	input logic [SEL_W-1:0] sel_i,
	output logic done_o,
	output logic [DATA_W-1:0] rdata_o,
	output logic [1:0] pi1_op_o,
	output logic [ADDR_W-1:0] pi1_addr_o,
	output logic [DATA_W-1:0] pi1_data_o,
	input logic [DATA_W-1:0] pi1_data_i,
	output logic [SEL_W-1:0] pi1_sel_o,
	input logic pi1_rdy_i
);

	logic idle;
	logic complete;

	assign idle = (pi1_op_o == MEM_NOOP);
	assign complete = !idle && pi1_rdy_i;

	// A request is only taken while the port is idle, which also forces
	// one idle cycle after every completion.
	always_ff @(posedge clk_i) begin
		done_o <= 1'b0;
		if (reset_i) begin
			pi1_op_o <= MEM_NOOP;
		end else if (complete) begin
			pi1_op_o <= MEM_NOOP;
			done_o <= 1'b1;
		end else if (idle && req_i) begin
			pi1_op_o <= we_i ? MEM_WRITE : MEM_READ;
		end
	end

	// Request fields stay put until the request completes.
	always_ff @(posedge clk_i) begin
		if (idle && req_i) begin
			pi1_addr_o <= addr_i;
			pi1_data_o <= wdata_i;
			pi1_sel_o <= we_i ? sel_i : '1; // Reads take the whole word.
		end
	end

	always_ff @(posedge clk_i) begin
		if (complete) begin
			rdata_o <= pi1_data_i;
		end
	end

endmodule

// ==== pu_sequencer.sv ====
// Instruction sequencer
module pu_sequencer import pu_pkg::*; (
	input logic clk_i,
	input logic reset_i,
	input logic [DATA_W-2:0] rstaddr_i,
	input logic [DATA_W-1:0] id_i,
	input logic intrqst_i,
	output logic intrdy_o,
	output logic halted_o,
	output logic mem_req_o,
	output logic mem_we_o,
	output logic [ADDR_W-1:0] mem_addr_o,
	output logic [DATA_W-1:0] mem_wdata_o,
	output logic [SEL_W-1:0] mem_sel_o,
	input logic mem_done_i,
	input logic [DATA_W-1:0] mem_rdata_i,
	output logic [$clog2(GPR_CNT)-1:0] gpr_ra_idx_o,
	output logic [$clog2(GPR_CNT)-1:0] gpr_rb_idx_o,
	output logic [$clog2(GPR_CNT)-1:0] gpr_rd_idx_o,
	output logic gpr_we_o,
	output logic [DATA_W-1:0] gpr_wdata_o,
	input logic [DATA_W-1:0] gpr_ra_data_i,
	input logic [DATA_W-1:0] gpr_rb_data_i,
	input logic [DATA_W-1:0] gpr_rd_data_i,
	output logic [OP_W-1:0] alu_op_o,
	output logic [DATA_W-1:0] alu_a_o,
	output logic [DATA_W-1:0] alu_b_o,
	input logic [DATA_W-1:0] alu_result_i,
	input logic alu_zero_i,
	output logic md_start_o,
	output logic [OP_W-1:0] md_op_o,
	input logic md_done_i,
	input logic [DATA_W-1:0] md_result_i
);

	logic [ST_W-1:0] state_q;
	logic [ADDR_W-1:0] pc_q; // Word address of the next instruction.
	logic [DATA_W-1:0] epc_q;
	logic int_en_q;
	pu_instr_u ir_q;
	logic [OP_W-1:0] opcode;
	logic [DATA_W-1:0] imm_sext;
	logic is_mem;
	logic is_imm;
	logic is_alu;
	logic is_md;
	logic irq_take;

	assign opcode = ir_q.r.opcode;
	assign imm_sext = {{16{ir_q.i.imm[15]}}, ir_q.i.imm};
	assign is_mem = opcode inside {OP_LD, OP_ST, OP_STB};
	assign is_imm = is_mem || opcode inside {OP_ADDI, OP_LI};
	assign is_alu = opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL,
		OP_ADDI, OP_LI};
	assign is_md = opcode inside {OP_MUL, OP_DIVU, OP_REMU};

	// Interrupts are only taken before a fetch or while halted.
	assign irq_take = intrqst_i && int_en_q;
	assign intrdy_o = int_en_q;
	assign halted_o = (state_q == ST_HALT);

	assign gpr_ra_idx_o = ir_q.r.ra;
	assign gpr_rb_idx_o = ir_q.r.rb;
	assign gpr_rd_idx_o = ir_q.r.rd;

	// Loads and stores borrow the adder to form ra plus imm.
	assign alu_op_o = is_mem ? OP_ADDI : opcode;
	assign alu_a_o = gpr_ra_data_i;
	assign alu_b_o = is_imm ? imm_sext : gpr_rb_data_i;

	assign md_op_o = opcode;
	assign md_start_o = (state_q == ST_EXEC) && is_md;

	always_comb begin
		mem_req_o = 1'b0;
		mem_we_o = 1'b0;
		mem_addr_o = pc_q;
		mem_wdata_o = gpr_rd_data_i;
		mem_sel_o = '1;
		if (state_q == ST_FETCH) begin
			mem_req_o = !irq_take;
		end else if (state_q == ST_EXEC && is_mem) begin
			mem_req_o = 1'b1;
			mem_we_o = (opcode != OP_LD);
			mem_addr_o = alu_result_i[DATA_W-1:2];
			if (opcode == OP_STB) begin
				mem_wdata_o = {SEL_W{gpr_rd_data_i[7:0]}};
				mem_sel_o = SEL_W'(1) << alu_result_i[1:0]; // One lane per byte.
			end
		end
	end

	always_comb begin
		gpr_we_o = 1'b0;
		gpr_wdata_o = alu_result_i;
		case (state_q)
			ST_EXEC: begin
				gpr_we_o = is_alu || opcode == OP_GETSYS;
				if (opcode == OP_GETSYS) begin
					gpr_wdata_o = (ir_q.i.imm == SYS_EPC) ? epc_q : id_i;
				end
			end
			ST_MWAIT: begin
				gpr_we_o = mem_done_i && opcode == OP_LD;
				gpr_wdata_o = mem_rdata_i;
			end
			ST_MDWAIT: begin
				gpr_we_o = md_done_i;
				gpr_wdata_o = md_result_i;
			end
			default: begin
				gpr_we_o = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q <= ST_FETCH;
			pc_q <= rstaddr_i[ADDR_W-1:0];
			int_en_q <= 1'b0;
		end else begin
			case (state_q)
				ST_FETCH: begin
					if (irq_take) begin
						pc_q <= INTR_VECTOR[DATA_W-1:2];
						int_en_q <= 1'b0;
					end else begin
						pc_q <= pc_q + 1'b1;
						state_q <= ST_FWAIT;
					end
				end
				ST_FWAIT: begin
					if (mem_done_i) begin
						state_q <= ST_EXEC;
					end
				end
				ST_EXEC: begin
					state_q <= ST_FETCH;
					if (is_mem) begin
						state_q <= ST_MWAIT;
					end else if (is_md) begin
						state_q <= ST_MDWAIT;
					end else if (opcode == OP_JZ && alu_zero_i) begin
						pc_q <= pc_q + imm_sext[ADDR_W-1:0];
					end else if (opcode == OP_EI) begin
						int_en_q <= 1'b1;
					end else if (opcode == OP_IRET) begin
						pc_q <= epc_q[DATA_W-1:2];
						int_en_q <= 1'b1;
					end else if (opcode == OP_HALT) begin
						state_q <= ST_HALT;
					end
				end
				ST_MWAIT: begin
					if (mem_done_i) begin
						state_q <= ST_FETCH;
					end
				end
				ST_MDWAIT: begin
					if (md_done_i) begin
						state_q <= ST_FETCH;
					end
				end
				ST_HALT: begin
					if (irq_take) begin
						pc_q <= INTR_VECTOR[DATA_W-1:2];
						int_en_q <= 1'b0;
						state_q <= ST_FETCH;
					end
				end
				default: begin
					state_q <= ST_FETCH;
				end
			endcase
		end
	end

	// EPC keeps the byte address of the instruction that was about to run.
	always_ff @(posedge clk_i) begin
		if (irq_take && (state_q == ST_FETCH || state_q == ST_HALT)) begin
			epc_q <= {pc_q, 2'b00};
		end
		if (state_q == ST_FWAIT && mem_done_i) begin
			ir_q <= mem_rdata_i;
		end
	end

endmodule

// ==== pu.sv ====
// Processing unit top level
module pu import pu_pkg::*; (
	input logic clk_i,
	input logic reset_i,
	output logic [1:0] pi1_op_o,
	output logic [ADDR_W-1:0] pi1_addr_o,
	output logic [DATA_W-1:0] pi1_data_o,
	input logic [DATA_W-1:0] pi1_data_i,
	output logic [SEL_W-1:0] pi1_sel_o,
	input logic pi1_rdy_i,
	input logic intrqst_i,
	output logic intrdy_o,
	output logic halted_o,
	input logic [DATA_W-2:0] rstaddr_i,
	input logic [DATA_W-1:0] id_i
);

	logic mem_req;
	logic mem_we;
	logic [ADDR_W-1:0] mem_addr;
	logic [DATA_W-1:0] mem_wdata;
	logic [SEL_W-1:0] mem_sel;
	logic mem_done;
	logic [DATA_W-1:0] mem_rdata;
	logic [$clog2(GPR_CNT)-1:0] gpr_ra_idx;
	logic [$clog2(GPR_CNT)-1:0] gpr_rb_idx;
	logic [$clog2(GPR_CNT)-1:0] gpr_rd_idx;
	logic gpr_we;
	logic [DATA_W-1:0] gpr_wdata;
	logic [DATA_W-1:0] gpr_ra_data;
	logic [DATA_W-1:0] gpr_rb_data;
	logic [DATA_W-1:0] gpr_rd_data;
	logic [OP_W-1:0] alu_op;
	logic [DATA_W-1:0] alu_a;
	logic [DATA_W-1:0] alu_b;
	logic [DATA_W-1:0] alu_result;
	logic alu_zero;
	logic md_start;
	logic [OP_W-1:0] md_op;
	logic md_done;
	logic [DATA_W-1:0] md_result;

	pu_sequencer u_sequencer (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.rstaddr_i(rstaddr_i),
		.id_i(id_i),
		.intrqst_i(intrqst_i),
		.intrdy_o(intrdy_o),
		.halted_o(halted_o),
		.mem_req_o(mem_req),
		.mem_we_o(mem_we),
		.mem_addr_o(mem_addr),
		.mem_wdata_o(mem_wdata),
		.mem_sel_o(mem_sel),
		.mem_done_i(mem_done),
		.mem_rdata_i(mem_rdata),
		.gpr_ra_idx_o(gpr_ra_idx),
		.gpr_rb_idx_o(gpr_rb_idx),
		.gpr_rd_idx_o(gpr_rd_idx),
		.gpr_we_o(gpr_we),
		.gpr_wdata_o(gpr_wdata),
		.gpr_ra_data_i(gpr_ra_data),
		.gpr_rb_data_i(gpr_rb_data),
		.gpr_rd_data_i(gpr_rd_data),
		.alu_op_o(alu_op),
		.alu_a_o(alu_a),
		.alu_b_o(alu_b),
		.alu_result_i(alu_result),
		.alu_zero_i(alu_zero),
		.md_start_o(md_start),
		.md_op_o(md_op),
		.md_done_i(md_done),
		.md_result_i(md_result)
	);

	pu_memctrl u_memctrl (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.req_i(mem_req),
		.we_i(mem_we),
		.addr_i(mem_addr),
		.wdata_i(mem_wdata),
		.sel_i(mem_sel),
		.done_o(mem_done),
		.rdata_o(mem_rdata),
		.pi1_op_o(pi1_op_o),
		.pi1_addr_o(pi1_addr_o),
		.pi1_data_o(pi1_data_o),
		.pi1_data_i(pi1_data_i),
		.pi1_sel_o(pi1_sel_o),
		.pi1_rdy_i(pi1_rdy_i)
	);

	pu_gpr u_gpr (
		.clk_i(clk_i),
		.ra_idx_i(gpr_ra_idx),
		.rb_idx_i(gpr_rb_idx),
		.rd_idx_i(gpr_rd_idx),
		.we_i(gpr_we),
		.wdata_i(gpr_wdata),
		.ra_data_o(gpr_ra_data),
		.rb_data_o(gpr_rb_data),
		.rd_data_o(gpr_rd_data)
	);

	pu_alu u_alu (
		.op_i(alu_op),
		.a_i(alu_a),
		.b_i(alu_b),
		.result_o(alu_result),
		.zero_o(alu_zero)
	);

	// Operands come straight from the ra and rb read ports.
	pu_muldiv u_muldiv (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.start_i(md_start),
		.op_i(md_op),
		.a_i(gpr_ra_data),
		.b_i(gpr_rb_data),
		.done_o(md_done),
		.result_o(md_result)
	);

endmodule

// ==== tb_clock.sv ====
// Testbench clock and reset
module tb_clock (
	output logic clk_o,
	output logic reset_o
);

	initial begin
		clk_o = 1'b0;
		reset_o = 1'b1;
		repeat (4) @(posedge clk_o);
		#1 reset_o = 1'b0;
	end

	always #5 clk_o = ~clk_o;

endmodule

// ==== pu_chk.sv ====
// Assertions on the pi1 port
module pu_chk import pu_pkg::*; (
	input logic clk_i,
	input logic reset_i,
	input logic [1:0] pi1_op_i,
	input logic [ADDR_W-1:0] pi1_addr_i,
	input logic [DATA_W-1:0] pi1_data_i,
	input logic [SEL_W-1:0] pi1_sel_i,
	input logic pi1_rdy_i
);

	// A waiting request keeps all of its fields.
	a_hold: assert property (@(posedge clk_i) disable iff (reset_i)
		(pi1_op_i != MEM_NOOP && !pi1_rdy_i) |=> ($stable(pi1_op_i) && $stable(pi1_addr_i)
		&& $stable(pi1_sel_i) && $stable(pi1_data_i)))
		else $error("pi1 request changed while waiting for ready");

	a_idle_after: assert property (@(posedge clk_i) disable iff (reset_i)
		(pi1_op_i != MEM_NOOP && pi1_rdy_i) |=> (pi1_op_i == MEM_NOOP))
		else $error("pi1 operation not idle after completion");

	a_reset_idle: assert property (@(posedge clk_i) reset_i |=> (pi1_op_i == MEM_NOOP))
		else $error("pi1 operation active during reset");

endmodule

bind pu_memctrl pu_chk u_chk (
	.clk_i(clk_i),
	.reset_i(reset_i),
	.pi1_op_i(pi1_op_o),
	.pi1_addr_i(pi1_addr_o),
	.pi1_data_i(pi1_data_o),
	.pi1_sel_i(pi1_sel_o),
	.pi1_rdy_i(pi1_rdy_i)
);

// ==== pu_tb.sv ====
// Processing unit testbench
module pu_tb import pu_pkg::*; ();

	localparam int CASE_BOUND = 400; // Cycles allowed per case.
	localparam logic [30:0] RST_ADDR = 31'h4000_0010;
	localparam logic [31:0] ID_WORD = 32'hC0DE_1234;
	localparam logic [15:0] RES_BASE = 16'h0C00; // Byte address of the result area.

	logic clk_i, reset_i;
	logic [1:0] pi1_op_o;
	logic [ADDR_W-1:0] pi1_addr_o;
	logic [DATA_W-1:0] pi1_data_o, pi1_data_i;
	logic [SEL_W-1:0] pi1_sel_o;
	logic pi1_rdy_i, intrqst_i, intrdy_o, halted_o;
	logic [DATA_W-2:0] rstaddr_i;
	logic [DATA_W-1:0] id_i;

	logic [31:0] mem [1024];
	logic [ADDR_W-1:0] exp_addr_q [$];
	logic [31:0] exp_data_q [$];
	logic [3:0] exp_sel_q [$];
	string exp_name_q [$];
	logic [31:0] rng;
	int prog_pc, res_off, case_count;
	int value_errs, other_errs, wait_cnt;
	bit armed, first_seen, built;

	tb_clock u_clock (.clk_o(clk_i), .reset_o(reset_i));

	pu dut (.*);

	assign pi1_data_i = mem[pi1_addr_o[9:0]];

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// Expected result of one operation; b is the sign-extended immediate for OP_ADDI.
	function automatic logic [31:0] ref_result(input logic [7:0] op, input logic [31:0] a,
		input logic [31:0] b);
		case (op)
			OP_ADD, OP_ADDI: return a + b;
			OP_SUB: return a - b;
			OP_AND: return a & b;
			OP_OR: return a | b;
			OP_XOR: return a ^ b;
			OP_SLL: return a << b[4:0];
			OP_SRL: return a >> b[4:0];
			OP_MUL: return a * b;
			OP_DIVU: return (b == 0) ? 32'hFFFF_FFFF : a / b;
			OP_REMU: return (b == 0) ? a : a % b;
			default: return 32'h0;
		endcase
	endfunction

	task automatic emit_r(input logic [7:0] op, input int rd, input int ra, input int rb);
		pu_instr_u w;
		w = '0;
		w.r.opcode = op;
		w.r.rd = rd[3:0];
		w.r.ra = ra[3:0];
		w.r.rb = rb[3:0];
		mem[prog_pc] = w;
		prog_pc++;
	endtask

	task automatic emit_i(input logic [7:0] op, input int rd, input int ra, input logic [15:0] imm);
		pu_instr_u w;
		w.i.opcode = op;
		w.i.rd = rd[3:0];
		w.i.ra = ra[3:0];
		w.i.imm = imm;
		mem[prog_pc] = w;
		prog_pc++;
	endtask

	// Needs r14 = 16; r13 is scratch for the zero-extended low half.
	task automatic load_const(input int r, input logic [31:0] v);
		emit_i(OP_LI, r, 0, v[31:16]);
		emit_r(OP_SLL, r, r, 14);
		emit_i(OP_LI, 13, 0, v[15:0]);
		emit_r(OP_SLL, 13, 13, 14);
		emit_r(OP_SRL, 13, 13, 14);
		emit_r(OP_OR, r, r, 13);
	endtask

	task automatic expect_write(input string name, input int byte_addr, input logic [31:0] data,
		input logic [3:0] sel);
		exp_name_q.push_back(name);
		exp_addr_q.push_back(ADDR_W'(byte_addr / 4));
		exp_data_q.push_back(data);
		exp_sel_q.push_back(sel);
	endtask

	task automatic store_result(input int r, input string name, input logic [31:0] v);
		emit_i(OP_ST, r, 15, res_off[15:0]);
		expect_write(name, int'(RES_BASE) + res_off, v, 4'hF);
		res_off += 4;
	endtask

	task automatic build_program();
		logic [7:0] ops [11];
		logic [31:0] a, b, v;
		logic [15:0] imm;
		logic [7:0] bytes [4];
		int halt_pc, saved_pc;
		ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_ADDI,
			OP_MUL, OP_DIVU, OP_REMU};
		for (int i = 0; i < 1024; i++) begin
			mem[i] = 32'hA5C3_0000 ^ (i * 32'h9E37_79B1);
		end
		prog_pc = int'(RST_ADDR[9:0]);
		res_off = 0;
		emit_i(OP_LI, 14, 0, 16'd16);
		emit_i(OP_LI, 15, 0, RES_BASE);
		for (int i = 0; i < 24; i++) begin
			a = next_rand();
			b = next_rand();
			if (i >= 22) begin
				b = 0; // Divide and remainder by zero.
			end
			load_const(1, a);
			load_const(2, b);
			if (ops[i % 11] == OP_ADDI) begin
				imm = b[15:0];
				emit_i(OP_ADDI, 3, 1, imm);
				v = ref_result(OP_ADDI, a, {{16{imm[15]}}, imm});
			end else begin
				emit_r(i >= 22 ? OP_DIVU + 8'(i - 22) : ops[i % 11], 3, 1, 2);
				v = ref_result(i >= 22 ? OP_DIVU + 8'(i - 22) : ops[i % 11], a, b);
			end
			store_result(3, $sformatf("case_%0d", i), v);
			case_count++;
		end
		// Byte stores to the four lanes of one word, then a word copy.
		for (int l = 0; l < 4; l++) begin
			bytes[l] = 8'(next_rand());
			emit_i(OP_LI, 2, 0, {8'h00, bytes[l]});
			emit_i(OP_STB, 2, 15, 16'(res_off + l));
			expect_write($sformatf("stb_lane_%0d", l), int'(RES_BASE) + res_off + l,
				{4{bytes[l]}}, 4'b0001 << l);
		end
		emit_i(OP_LD, 3, 15, res_off[15:0]);
		res_off += 4;
		store_result(3, "ld_st_merge", {bytes[3], bytes[2], bytes[1], bytes[0]});
		emit_i(OP_LI, 5, 0, 16'h5A5A);
		emit_i(OP_LI, 6, 0, 16'h0C3C);
		emit_i(OP_LI, 4, 0, 16'h0);
		emit_i(OP_JZ, 0, 4, 16'd1);
		emit_i(OP_ST, 5, 15, res_off[15:0]); // Skipped.
		emit_i(OP_LI, 4, 0, 16'h1);
		emit_i(OP_JZ, 0, 4, 16'd1);
		store_result(6, "jz_not_taken", 32'h0C3C);
		emit_i(OP_GETSYS, 7, 0, SYS_ID);
		store_result(7, "sys_id", ID_WORD);
		emit_i(OP_EI, 0, 0, 16'h0);
		halt_pc = prog_pc;
		emit_i(OP_HALT, 0, 0, 16'h0);
		// The handler lives at the interrupt vector and runs before the post-halt store.
		saved_pc = prog_pc;
		prog_pc = int'(INTR_VECTOR[11:2]);
		emit_i(OP_GETSYS, 8, 0, SYS_EPC);
		store_result(8, "epc", 32'((halt_pc + 1) * 4));
		emit_r(OP_IRET, 0, 0, 0);
		prog_pc = saved_pc;
		store_result(5, "after_halt", 32'h5A5A);
		emit_i(OP_HALT, 0, 0, 16'h0);
		case_count += 12;
		if (prog_pc >= int'(INTR_VECTOR[11:2])) begin
			$display("Program runs into the interrupt handler area");
			other_errs++;
		end
	endtask

	// Ready answers each request after 0 to 3 waiting cycles.
	always @(posedge clk_i) begin
		#1;
		if (reset_i || pi1_op_o == MEM_NOOP) begin
			pi1_rdy_i = 1'b0;
			armed = 1'b0;
		end else if (!pi1_rdy_i) begin
			if (!armed) begin
				armed = 1'b1;
				wait_cnt = next_rand() % 4;
			end
			if (wait_cnt == 0) begin
				pi1_rdy_i = 1'b1;
				armed = 1'b0;
			end else begin
				wait_cnt--;
			end
		end
	end

	always @(posedge clk_i) begin
		if (!reset_i && pi1_op_o == MEM_WRITE && pi1_rdy_i) begin
			for (int l = 0; l < 4; l++) begin
				if (pi1_sel_o[l]) begin
					mem[pi1_addr_o[9:0]][8*l +: 8] = pi1_data_o[8*l +: 8];
				end
			end
		end
	end

	// Compares completed pi1 requests with the expected queue.
	always @(posedge clk_i) begin
		logic [31:0] mask;
		logic [ADDR_W-1:0] ea;
		logic [31:0] ed;
		logic [3:0] es;
		string en;
		if (!reset_i && pi1_op_o != MEM_NOOP && pi1_rdy_i) begin
			if (!first_seen) begin
				first_seen = 1'b1;
				if (pi1_op_o != MEM_READ || pi1_addr_o != RST_ADDR[ADDR_W-1:0]) begin
					$display("ERROR first_fetch: expected %h, actual %h",
						RST_ADDR[ADDR_W-1:0], pi1_addr_o);
					value_errs++;
				end
			end
			if (pi1_op_o == MEM_WRITE && pi1_addr_o >= 30'h300 && pi1_addr_o < 30'h400) begin
				if (exp_data_q.size() == 0) begin
					$display("Unexpected write of %h to word %h", pi1_data_o, pi1_addr_o);
					other_errs++;
				end else begin
					ea = exp_addr_q.pop_front();
					ed = exp_data_q.pop_front();
					es = exp_sel_q.pop_front();
					en = exp_name_q.pop_front();
					mask = {{8{es[3]}}, {8{es[2]}}, {8{es[1]}}, {8{es[0]}}};
					if (pi1_addr_o != ea) begin
						$display("ERROR %s addr: expected %h, actual %h", en, ea, pi1_addr_o);
						value_errs++;
					end
					if (pi1_sel_o != es) begin
						$display("ERROR %s sel: expected %h, actual %h", en, es, pi1_sel_o);
						value_errs++;
					end
					if ((pi1_data_o & mask) != (ed & mask)) begin
						$display("ERROR %s: expected %h, actual %h", en, ed & mask,
							pi1_data_o & mask);
						value_errs++;
					end
				end
			end
		end
	end

	initial begin
		wait (built);
		#(case_count * CASE_BOUND * 10);
		$display("Timeout: the program did not finish in time");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		pi1_rdy_i = 1'b0;
		intrqst_i = 1'b0;
		rstaddr_i = RST_ADDR;
		id_i = ID_WORD;
		rng = 32'd74122;
		build_program();
		built = 1'b1;
		@(posedge clk_i);
		@(posedge clk_i);
		#2;
		if (pi1_op_o != MEM_NOOP || intrdy_o || halted_o) begin
			$display("Outputs are not idle during reset");
			other_errs++;
		end
		wait (halted_o);
		if (!intrdy_o) begin
			$display("Interrupts are not enabled at the halt");
			other_errs++;
		end
		@(posedge clk_i);
		#1 intrqst_i = 1'b1;
		@(posedge clk_i);
		#1 intrqst_i = 1'b0;
		wait (!halted_o);
		wait (halted_o);
		repeat (4) @(posedge clk_i);
		if (exp_data_q.size() != 0) begin
			$display("%0d expected writes never happened", exp_data_q.size());
			other_errs++;
		end
		$display("Checks finished: %0d value errors, %0d other errors", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
pu_pkg.sv
pu_gpr.sv
pu_alu.sv
pu_muldiv.sv
pu_memctrl.sv
pu_sequencer.sv
pu.sv
tb_clock.sv
pu_chk.sv
pu_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module pu_tb -f sources.f -o pu_sim
./obj_dir/pu_sim | tee sim.log
if grep -q "Simulation failed" sim.log; then
	exit 1
fi
exit 0
